/* flist.f */
source/mcu_pkg.sv
source/obi_bus_if.sv
source/system_bus.sv
source/memory_subsystem.sv
source/soc_ctrl.sv
source/rv_timer.sv
source/gpio.sv
source/mini_mcu.sv
test/mini_mcu_props.sv
test/tb_mini_mcu.sv

/* Bender.yml */
package:
  name: mini_mcu

sources:
  - source/mcu_pkg.sv
  - source/obi_bus_if.sv
  - source/system_bus.sv
  - source/memory_subsystem.sv
  - source/soc_ctrl.sv
  - source/rv_timer.sv
  - source/gpio.sv
  - source/mini_mcu.sv
  - target: test
    files:
      - test/mini_mcu_props.sv
      - test/tb_mini_mcu.sv

/* test/tb_mini_mcu.sv */
// ##############################
// default parameters only and a RAM model of 2 x 256 words
// inputs change on the falling clock edge
// ##############################
`timescale 1ns/10ps
`default_nettype none

module tb_mini_mcu;

  import mcu_pkg::*;

  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned RAM_WORDS    = 512;
  // ram, unmapped, soc_ctrl, timer, gpio, burst
  localparam int unsigned TEST_CYCLES  = 260 + 30 + 40 + 80 + 40 + 30;
  localparam int unsigned WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD + 400;

  logic        clk_i;
  logic        rst_i;
  logic        boot_select_i;
  logic        bus_req_i;
  logic        bus_we_i;
  logic [31:0] bus_addr_i;
  logic [31:0] bus_wdata_i;
  logic        bus_gnt_o;
  logic        bus_rvalid_o;
  logic [31:0] bus_rdata_o;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic        irq_timer_o;
  logic [31:0] gpio_i;
  logic [31:0] gpio_o;
  logic [31:0] gpio_en_o;

  integer      seed = 32'hbf9b;
  string       test_name;
  int unsigned test_checks;
  int unsigned test_errors;
  int unsigned total_checks;
  int unsigned total_errors;
  int unsigned tests_run;
  logic [31:0] ram_model [RAM_WORDS];
  bit          ram_written [RAM_WORDS];

  mini_mcu i_mini_mcu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .boot_select_i (boot_select_i),
    .bus_req_i     (bus_req_i),
    .bus_we_i      (bus_we_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_gnt_o     (bus_gnt_o),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .irq_timer_o   (irq_timer_o),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o),
    .gpio_en_o     (gpio_en_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_eq(input logic [31:0] expected, input logic [31:0] actual);
    test_checks++;
    assert (actual === expected) else begin
      test_errors++;
      $display("** Error: %s expected %h actual %h", test_name, expected, actual);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    test_checks++;
    assert (cond) else begin
      test_errors++;
      $display("%s: %s", test_name, what);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %-10s %0d checks, %0d errors", test_name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    tests_run++;
  endtask

  // one access that returns once the response is visible
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_wdata_i = wdata;
    @(negedge clk_i);
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    while (!bus_rvalid_o && waited < 4) begin
      @(negedge clk_i);
      waited++;
    end
    check_true(bus_rvalid_o, $sformatf("no response for address %h", addr));
    rdata = bus_rdata_o;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] expected);
    logic [31:0] rdata;
    bus_access(1'b0, addr, '0, rdata);
    check_eq(expected, rdata);
  endtask

  // a new read every cycle and each response sampled one cycle after its grant
  task automatic read_burst(input logic [31:0] addrs [$], output logic [31:0] data [$]);
    data = {};
    @(negedge clk_i);
    foreach (addrs[i]) begin
      bus_req_i  = 1'b1;
      bus_we_i   = 1'b0;
      bus_addr_i = addrs[i];
      @(negedge clk_i);
      check_true(bus_rvalid_o, $sformatf("burst response %0d missing", i));
      data.push_back(bus_rdata_o);
    end
    bus_req_i = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] exit_val;
    logic [31:0] out_val;
    logic [31:0] en_val;
    logic [31:0] burst_addr [$];
    logic [31:0] burst_data [$];
    logic [31:0] burst_exp [$];
    int unsigned i;
    int unsigned idx;
    int unsigned irq_early;

    clk_i         = 1'b0;
    rst_i         = 1'b1;
    boot_select_i = 1'b0;
    bus_req_i     = 1'b0;
    bus_we_i      = 1'b0;
    bus_addr_i    = '0;
    bus_wdata_i   = '0;
    gpio_i        = '0;
    total_checks  = 0;
    total_errors  = 0;
    tests_run     = 0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;

    start_test("ram");
    // consecutive words alternate banks
    for (i = 0; i < 8; i++) begin
      data = $random(seed);
      write_word(RAM_BASE + 32'(i * 4), data);
      ram_model[i]   = data;
      ram_written[i] = 1'b1;
    end
    for (i = 0; i < 32; i++) begin
      addr = {16'h0000, 14'($random(seed)), 2'b00};
      data = $random(seed);
      write_word(addr, data);
      // higher bits alias into 2 KiB of RAM
      idx              = addr[10:2];
      ram_model[idx]   = data;
      ram_written[idx] = 1'b1;
    end
    for (i = 0; i < RAM_WORDS; i++) begin
      if (ram_written[i]) begin
        read_check(RAM_BASE + 32'(i * 4), ram_model[i]);
      end
    end
    end_test();

    start_test("unmapped");
    read_check(32'h1000_0000, BUS_ERR_DATA);
    read_check(32'h2003_0004, BUS_ERR_DATA);
    read_check(32'hFFFF_FFFC, BUS_ERR_DATA);
    // low bits match RAM word 0
    write_word(32'h4000_0000, ~ram_model[0]);
    read_check(RAM_BASE, ram_model[0]);
    end_test();

    start_test("soc_ctrl");
    exit_val = $random(seed);
    write_word(SOC_CTRL_BASE + SOC_EXIT_VALUE_OFFS, exit_val);
    read_check(SOC_CTRL_BASE + SOC_EXIT_VALUE_OFFS, exit_val);
    check_eq(exit_val, exit_value_o);
    check_true(!exit_valid_o, "exit valid high before any write");
    write_word(SOC_CTRL_BASE + SOC_EXIT_VALID_OFFS, 32'h1);
    check_true(exit_valid_o, "exit valid did not rise after the write");
    write_word(SOC_CTRL_BASE + SOC_EXIT_VALID_OFFS, 32'h0);
    repeat (2) @(negedge clk_i);
    check_true(exit_valid_o, "exit valid fell after writing zero");
    boot_select_i = 1'b0;
    read_check(SOC_CTRL_BASE + SOC_BOOT_SEL_OFFS, 32'h0);
    boot_select_i = 1'b1;
    read_check(SOC_CTRL_BASE + SOC_BOOT_SEL_OFFS, 32'h1);
    end_test();

    start_test("timer");
    write_word(TIMER_BASE + TIMER_MTIME_OFFS, 32'd1000);
    write_word(TIMER_BASE + TIMER_CMP_OFFS, 32'd1020);
    read_check(TIMER_BASE + TIMER_CMP_OFFS, 32'd1020);
    // still disabled, so mtime holds
    read_check(TIMER_BASE + TIMER_MTIME_OFFS, 32'd1000);
    write_word(TIMER_BASE + TIMER_CTRL_OFFS, 32'h1);
    irq_early = 0;
    for (i = 0; i < 15; i++) begin
      if (irq_timer_o) begin
        irq_early++;
      end
      @(negedge clk_i);
    end
    check_true(irq_early == 0, "timer interrupt fired before mtime reached compare");
    repeat (10) @(negedge clk_i);
    check_true(irq_timer_o, "timer interrupt not raised after compare was reached");
    bus_access(1'b0, TIMER_BASE + TIMER_MTIME_OFFS, '0, t0);
    bus_access(1'b0, TIMER_BASE + TIMER_MTIME_OFFS, '0, t1);
    check_true(t1 > t0, "mtime did not increase between two reads");
    write_word(TIMER_BASE + TIMER_CTRL_OFFS, 32'h0);
    @(negedge clk_i);
    check_true(!irq_timer_o, "timer interrupt stayed high after disabling");
    end_test();

    start_test("gpio");
    out_val = $random(seed);
    en_val  = $random(seed);
    write_word(GPIO_BASE + GPIO_OUT_OFFS, out_val);
    write_word(GPIO_BASE + GPIO_EN_OFFS, en_val);
    check_eq(out_val, gpio_o);
    check_eq(en_val, gpio_en_o);
    read_check(GPIO_BASE + GPIO_OUT_OFFS, out_val);
    read_check(GPIO_BASE + GPIO_EN_OFFS, en_val);
    gpio_i = $random(seed);
    repeat (3) @(negedge clk_i);
    read_check(GPIO_BASE + GPIO_IN_OFFS, gpio_i);
    end_test();

    start_test("burst");
    burst_addr = {RAM_BASE + 32'h4, SOC_CTRL_BASE + SOC_EXIT_VALUE_OFFS,
                  GPIO_BASE + GPIO_OUT_OFFS, 32'h3000_0000,
                  TIMER_BASE + TIMER_CMP_OFFS, RAM_BASE + 32'h8,
                  GPIO_BASE + GPIO_EN_OFFS};
    burst_exp  = {ram_model[1], exit_val, out_val, BUS_ERR_DATA,
                  32'd1020, ram_model[2], en_val};
    read_burst(burst_addr, burst_data);
    foreach (burst_exp[k]) begin
      check_eq(burst_exp[k], burst_data[k]);
    end
    end_test();

    repeat (2) @(negedge clk_i);
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, total_checks, total_errors, i_mini_mcu.i_mini_mcu_props.fail_count);
    total_errors += i_mini_mcu.i_mini_mcu_props.fail_count;
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/mini_mcu_props.sv */
// ##############################
// bound to mini_mcu and clocked on clk_i
// reset is synchronous and active high
// ##############################
`timescale 1ns/10ps
`default_nettype none

module mini_mcu_props (
  input logic clk_i,
  input logic rst_i,
  input logic bus_req_i,
  input logic bus_gnt_o,
  input logic bus_rvalid_o,
  input logic exit_valid_o,
  input logic irq_timer_o
);

  int unsigned fail_count = 0;

  gnt_is_req: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_gnt_o == bus_req_i)
  else begin
    fail_count++;
    $error("grant differs from request");
  end

  // one response per grant, exactly one cycle later
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_gnt_o |=> bus_rvalid_o)
  else begin
    fail_count++;
    $error("no response one cycle after a grant");
  end

  rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_rvalid_o |-> $past(bus_gnt_o))
  else begin
    fail_count++;
    $error("response without a grant in the cycle before");
  end

  exit_valid_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    exit_valid_o |=> exit_valid_o)
  else begin
    fail_count++;
    $error("exit valid fell outside reset");
  end

  low_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !bus_rvalid_o && !exit_valid_o && !irq_timer_o)
  else begin
    fail_count++;
    $error("status outputs not low after reset");
  end

endmodule

bind mini_mcu mini_mcu_props i_mini_mcu_props (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .bus_req_i    (bus_req_i),
  .bus_gnt_o    (bus_gnt_o),
  .bus_rvalid_o (bus_rvalid_o),
  .exit_valid_o (exit_valid_o),
  .irq_timer_o  (irq_timer_o)
);

`default_nettype wire

/* source/mini_mcu.sv */
// ############################
// external master must take rvalid when it comes
// gnt is combinational from req
// ############################
`timescale 1ns/10ps
`default_nettype none

module mini_mcu #(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256,
  parameter int unsigned NUM_GPIO   = 32
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          boot_select_i,
  input  logic                          bus_req_i,
  input  logic                          bus_we_i,
  input  logic [mcu_pkg::BUS_WIDTH-1:0] bus_addr_i,
  input  logic [mcu_pkg::BUS_WIDTH-1:0] bus_wdata_i,
  output logic                          bus_gnt_o,
  output logic                          bus_rvalid_o,
  output logic [mcu_pkg::BUS_WIDTH-1:0] bus_rdata_o,
  output logic                          exit_valid_o,
  output logic [mcu_pkg::BUS_WIDTH-1:0] exit_value_o,
  output logic                          irq_timer_o,
  input  logic [NUM_GPIO-1:0]           gpio_i,
  output logic [NUM_GPIO-1:0]           gpio_o,
  output logic [NUM_GPIO-1:0]           gpio_en_o
);

  obi_bus_if ram_bus ();
  obi_bus_if soc_ctrl_bus ();
  obi_bus_if timer_bus ();
  obi_bus_if gpio_bus ();

  system_bus i_system_bus (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .ram_o        (ram_bus),
    .soc_ctrl_o   (soc_ctrl_bus),
    .timer_o      (timer_bus),
    .gpio_o       (gpio_bus)
  );

  memory_subsystem #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS)
  ) i_memory_subsystem (
    .clk_i (clk_i),
    .ram_i (ram_bus)
  );

  soc_ctrl i_soc_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .bus_i         (soc_ctrl_bus)
  );

  rv_timer i_rv_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .irq_timer_o (irq_timer_o),
    .bus_i       (timer_bus)
  );

  gpio #(
    .NUM_GPIO (NUM_GPIO)
  ) i_gpio (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .bus_i     (gpio_bus)
  );

endmodule

`default_nettype wire

/* source/gpio.sv */
// ############################
// NUM_GPIO from 1 to 32
// inputs pass a two-flop synchronizer
// ############################
`timescale 1ns/10ps
`default_nettype none

module gpio #(
  parameter int unsigned NUM_GPIO = 32
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_en_o,
  obi_bus_if.target           bus_i
);

  import mcu_pkg::*;

  logic [3:0]          offs;
  logic [NUM_GPIO-1:0] in_meta_q;
  logic [NUM_GPIO-1:0] in_sync_q;

  assign offs = bus_i.addr[3:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_meta_q    <= '0;
      in_sync_q    <= '0;
      gpio_o       <= '0;
      gpio_en_o    <= '0;
      bus_i.rvalid <= 1'b0;
    end else begin
      in_meta_q    <= gpio_i;
      in_sync_q    <= in_meta_q;
      bus_i.rvalid <= bus_i.req;
      if (bus_i.req && bus_i.we) begin
        case (offs)
          GPIO_OUT_OFFS: gpio_o    <= bus_i.wdata[NUM_GPIO-1:0];
          GPIO_EN_OFFS:  gpio_en_o <= bus_i.wdata[NUM_GPIO-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= '0;
      if (!bus_i.we) begin
        case (offs)
          GPIO_IN_OFFS:  bus_i.rdata <= BUS_WIDTH'(in_sync_q);
          GPIO_OUT_OFFS: bus_i.rdata <= BUS_WIDTH'(gpio_o);
          GPIO_EN_OFFS:  bus_i.rdata <= BUS_WIDTH'(gpio_en_o);
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* source/rv_timer.sv */
// ############################
// 32-bit mtime wraps silently
// irq is a level that clears on disable
// ############################
`timescale 1ns/10ps
`default_nettype none

module rv_timer (
  input  logic      clk_i,
  input  logic      rst_i,
  output logic      irq_timer_o,
  obi_bus_if.target bus_i
);

  import mcu_pkg::*;

  logic [3:0]           offs;
  logic [BUS_WIDTH-1:0] mtime_q;
  logic [BUS_WIDTH-1:0] cmp_q;
  logic                 en_q;
  logic                 wr;

  assign offs = bus_i.addr[3:0];
  assign wr   = bus_i.req && bus_i.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q      <= '0;
      cmp_q        <= '0;
      en_q         <= 1'b0;
      irq_timer_o  <= 1'b0;
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
      // bus load wins over counting
      if (wr && offs == TIMER_MTIME_OFFS) begin
        mtime_q <= bus_i.wdata;
      end else if (en_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && offs == TIMER_CMP_OFFS) begin
        cmp_q <= bus_i.wdata;
      end
      if (wr && offs == TIMER_CTRL_OFFS) begin
        en_q <= bus_i.wdata[0];
      end
      irq_timer_o <= en_q && (mtime_q >= cmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= '0;
      if (!bus_i.we) begin
        case (offs)
          TIMER_MTIME_OFFS: bus_i.rdata <= mtime_q;
          TIMER_CMP_OFFS:   bus_i.rdata <= cmp_q;
          TIMER_CTRL_OFFS:  bus_i.rdata <= BUS_WIDTH'(en_q);
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* source/soc_ctrl.sv */
// ############################
// exit valid is sticky until reset
// offsets alias every 16 bytes
// ############################
`timescale 1ns/10ps
`default_nettype none

module soc_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         boot_select_i,
  output logic                         exit_valid_o,
  output logic [mcu_pkg::BUS_WIDTH-1:0] exit_value_o,
  obi_bus_if.target                    bus_i
);

  import mcu_pkg::*;

  logic [3:0] offs;

  assign offs = bus_i.addr[3:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
      bus_i.rvalid <= 1'b0;
    end else begin
      bus_i.rvalid <= bus_i.req;
      if (bus_i.req && bus_i.we) begin
        case (offs)
          SOC_EXIT_VALUE_OFFS: exit_value_o <= bus_i.wdata;
          // only a one sets it
          SOC_EXIT_VALID_OFFS: exit_valid_o <= exit_valid_o | bus_i.wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bus_i.rdata <= '0;
      if (!bus_i.we) begin
        case (offs)
          SOC_EXIT_VALUE_OFFS: bus_i.rdata <= exit_value_o;
          SOC_EXIT_VALID_OFFS: bus_i.rdata <= BUS_WIDTH'(exit_valid_o);
          SOC_BOOT_SEL_OFFS:   bus_i.rdata <= BUS_WIDTH'(boot_select_i);
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* source/memory_subsystem.sv */
// ############################
// NUM_BANKS must be a power of two and at least 2
// addresses wrap within the RAM size
// ############################
`timescale 1ns/10ps
`default_nettype none

module memory_subsystem #(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic      clk_i,
  obi_bus_if.target ram_i
);

  import mcu_pkg::*;

  localparam int unsigned BANK_BITS = $clog2(NUM_BANKS);
  localparam int unsigned ROW_BITS  = $clog2(BANK_WORDS);

  logic [BANK_BITS-1:0] bank_sel;
  logic [BANK_BITS-1:0] bank_q;
  logic [ROW_BITS-1:0]  row_sel;
  logic                 we_q;
  logic [BUS_WIDTH-1:0] bank_rdata [NUM_BANKS];

  // word interleave with bank bits right above the byte offset
  assign bank_sel = ram_i.addr[2 +: BANK_BITS];
  assign row_sel  = ram_i.addr[2 + BANK_BITS +: ROW_BITS];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [BUS_WIDTH-1:0] mem [BANK_WORDS];
    logic [BUS_WIDTH-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
      if (ram_i.req && (bank_sel == BANK_BITS'(b))) begin
        if (ram_i.we) begin
          mem[row_sel] <= ram_i.wdata;
        end else begin
          rdata_q <= mem[row_sel];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  always_ff @(posedge clk_i) begin
    ram_i.rvalid <= ram_i.req;
    if (ram_i.req) begin
      bank_q <= bank_sel;
      we_q   <= ram_i.we;
    end
  end

  // writes answer with zero
  assign ram_i.rdata = we_q ? '0 : bank_rdata[bank_q];

endmodule

`default_nettype wire

/* source/system_bus.sv */
// ############################
// single master and no arbitration
// response comes one cycle after each request
// ############################
`timescale 1ns/10ps
`default_nettype none

module system_bus (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         bus_req_i,
  input  logic                         bus_we_i,
  input  logic [mcu_pkg::BUS_WIDTH-1:0] bus_addr_i,
  input  logic [mcu_pkg::BUS_WIDTH-1:0] bus_wdata_i,
  output logic                         bus_gnt_o,
  output logic                         bus_rvalid_o,
  output logic [mcu_pkg::BUS_WIDTH-1:0] bus_rdata_o,
  obi_bus_if.manager                   ram_o,
  obi_bus_if.manager                   soc_ctrl_o,
  obi_bus_if.manager                   timer_o,
  obi_bus_if.manager                   gpio_o
);

  import mcu_pkg::*;

  bus_target_e tgt;
  bus_target_e resp_tgt_q;
  logic        resp_pend_q;

  always_comb begin
    case (bus_addr_i & REGION_MASK)
      RAM_BASE:      tgt = TGT_RAM;
      SOC_CTRL_BASE: tgt = TGT_SOC_CTRL;
      TIMER_BASE:    tgt = TGT_TIMER;
      GPIO_BASE:     tgt = TGT_GPIO;
      default:       tgt = TGT_NONE;
    endcase
  end

  // targets never stall
  assign bus_gnt_o = bus_req_i;

  assign ram_o.req      = bus_req_i && (tgt == TGT_RAM);
  assign soc_ctrl_o.req = bus_req_i && (tgt == TGT_SOC_CTRL);
  assign timer_o.req    = bus_req_i && (tgt == TGT_TIMER);
  assign gpio_o.req     = bus_req_i && (tgt == TGT_GPIO);

  assign ram_o.we      = bus_we_i;
  assign soc_ctrl_o.we = bus_we_i;
  assign timer_o.we    = bus_we_i;
  assign gpio_o.we     = bus_we_i;

  assign ram_o.addr      = bus_addr_i;
  assign soc_ctrl_o.addr = bus_addr_i;
  assign timer_o.addr    = bus_addr_i;
  assign gpio_o.addr     = bus_addr_i;

  assign ram_o.wdata      = bus_wdata_i;
  assign soc_ctrl_o.wdata = bus_wdata_i;
  assign timer_o.wdata    = bus_wdata_i;
  assign gpio_o.wdata     = bus_wdata_i;

  // remember who owes the next response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_pend_q <= 1'b0;
      resp_tgt_q  <= TGT_NONE;
    end else begin
      resp_pend_q <= bus_req_i;
      if (bus_req_i) begin
        resp_tgt_q <= tgt;
      end
    end
  end

  always_comb begin
    case (resp_tgt_q)
      TGT_RAM: begin
        bus_rvalid_o = resp_pend_q && ram_o.rvalid;
        bus_rdata_o  = ram_o.rdata;
      end
      TGT_SOC_CTRL: begin
        bus_rvalid_o = resp_pend_q && soc_ctrl_o.rvalid;
        bus_rdata_o  = soc_ctrl_o.rdata;
      end
      TGT_TIMER: begin
        bus_rvalid_o = resp_pend_q && timer_o.rvalid;
        bus_rdata_o  = timer_o.rdata;
      end
      TGT_GPIO: begin
        bus_rvalid_o = resp_pend_q && gpio_o.rvalid;
        bus_rdata_o  = gpio_o.rdata;
      end
      default: begin
        // an unmapped address answers locally and drops writes
        bus_rvalid_o = resp_pend_q;
        bus_rdata_o  = BUS_ERR_DATA;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/obi_bus_if.sv */
// ############################
// one bus-to-target link, word accesses only
// no grant since every target is always ready
// ############################
`timescale 1ns/10ps
`default_nettype none

interface obi_bus_if;

  import mcu_pkg::*;

  logic                 req;
  logic                 we;
  logic [BUS_WIDTH-1:0] addr;
  logic [BUS_WIDTH-1:0] wdata;
  logic                 rvalid;
  logic [BUS_WIDTH-1:0] rdata;

  modport manager (
    output req, we, addr, wdata,
    input  rvalid, rdata
  );

  modport target (
    input  req, we, addr, wdata,
    output rvalid, rdata
  );

endinterface

`default_nettype wire

/* source/mcu_pkg.sv */
// ############################
// address map and register offsets
// only the upper 16 address bits select a region
// ############################
`default_nettype none

package mcu_pkg;

  localparam int unsigned BUS_WIDTH = 32;

  // region bases
  localparam logic [BUS_WIDTH-1:0] RAM_BASE      = 32'h0000_0000;
  localparam logic [BUS_WIDTH-1:0] SOC_CTRL_BASE = 32'h2000_0000;
  localparam logic [BUS_WIDTH-1:0] TIMER_BASE    = 32'h2001_0000;
  localparam logic [BUS_WIDTH-1:0] GPIO_BASE     = 32'h2002_0000;
  localparam logic [BUS_WIDTH-1:0] REGION_MASK   = 32'hFFFF_0000;

  typedef enum logic [2:0] {
    TGT_RAM,
    TGT_SOC_CTRL,
    TGT_TIMER,
    TGT_GPIO,
    TGT_NONE
  } bus_target_e;

  // returned for reads outside every region
  localparam logic [BUS_WIDTH-1:0] BUS_ERR_DATA = 32'hBADCAB1E;

  localparam logic [3:0] SOC_EXIT_VALUE_OFFS = 4'h0;
  localparam logic [3:0] SOC_EXIT_VALID_OFFS = 4'h4;
  localparam logic [3:0] SOC_BOOT_SEL_OFFS   = 4'h8;

  localparam logic [3:0] TIMER_MTIME_OFFS = 4'h0;
  localparam logic [3:0] TIMER_CMP_OFFS   = 4'h4;
  localparam logic [3:0] TIMER_CTRL_OFFS  = 4'h8;

  localparam logic [3:0] GPIO_IN_OFFS  = 4'h0;
  localparam logic [3:0] GPIO_OUT_OFFS = 4'h4;
  localparam logic [3:0] GPIO_EN_OFFS  = 4'h8;

endpackage

`default_nettype wire
